// File: addr_collector.sv
// Round-robin merge of per-bank released regions into one buffered stream
`timescale 1ns/10ps

module addr_collector (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic [lbuf_pkg::N_BANK-1:0]  i_bank_rdy,
	input  logic [lbuf_pkg::LBW-1:0]     i_bank_addr [lbuf_pkg::N_BANK],
	input  logic [lbuf_pkg::LBW:0]       i_bank_size [lbuf_pkg::N_BANK],
	output logic [lbuf_pkg::N_BANK-1:0]  o_bank_ack,
	output logic                         o_linear_rdy,
	input  logic                         i_linear_ack,
	output logic [lbuf_pkg::BANK_BW-1:0] o_linear_bank,
	output logic [lbuf_pkg::LBW-1:0]     o_linear_addr,
	output logic [lbuf_pkg::LBW:0]       o_linear_size
);

	// First bank to look at
	logic [lbuf_pkg::BANK_BW-1:0] rr_ptr_r;
	logic [lbuf_pkg::BANK_BW-1:0] scan_idx;
	logic [lbuf_pkg::BANK_BW-1:0] sel_bank;
	logic sel_found;
	logic grant;

	lbuf_pkg::out_entry_t push_entry;
	lbuf_pkg::out_entry_t head_entry;
	logic fifo_full;
	logic fifo_empty;

	// ====================
	// Arbiter
	// ====================
	always_comb begin
		sel_found = 1'b0;
		sel_bank = rr_ptr_r;
		scan_idx = rr_ptr_r;
		// Walk the banks starting at the pointer
		for (int k = 0; k < lbuf_pkg::N_BANK; k++) begin
			scan_idx = lbuf_pkg::BANK_BW'((int'(rr_ptr_r) + k) % lbuf_pkg::N_BANK);
			if (!sel_found && i_bank_rdy[scan_idx]) begin
				sel_found = 1'b1;
				sel_bank = scan_idx;
			end
		end
	end

	// No grant while the output buffer is full
	assign grant = sel_found && !fifo_full;

	always_comb begin
		o_bank_ack = '0;
		o_bank_ack[sel_bank] = grant;
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			rr_ptr_r <= '0;
		end else if (grant) begin
			// Step past the bank just served
			if (sel_bank == lbuf_pkg::BANK_BW'(lbuf_pkg::N_BANK - 1)) begin
				rr_ptr_r <= '0;
			end else begin
				rr_ptr_r <= sel_bank + 1'b1;
			end
		end
	end

	// ====================
	// Output buffer
	// ====================
	assign push_entry.bank = sel_bank;
	assign push_entry.addr = i_bank_addr[sel_bank];
	assign push_entry.size = i_bank_size[sel_bank];

	addr_fifo #(
		.T(lbuf_pkg::out_entry_t),
		.DEPTH(lbuf_pkg::FIFO_DEPTH)
	) u_out_fifo (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_push(grant),
		.i_data(push_entry),
		.i_pop(o_linear_rdy && i_linear_ack),
		.o_data(head_entry),
		.o_full(fifo_full),
		.o_empty(fifo_empty)
	);

	assign o_linear_rdy = !fifo_empty;
	assign o_linear_bank = head_entry.bank;
	assign o_linear_addr = head_entry.addr;
	assign o_linear_size = head_entry.size;

	// Offered entry holds until it is taken
	a_out_stable: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		o_linear_rdy && !i_linear_ack |=> o_linear_rdy && $stable(o_linear_bank)
			&& $stable(o_linear_addr) && $stable(o_linear_size)
	) else $error("addr_collector changed an unacknowledged output");

endmodule

// File: addr_fifo.sv
// Shift-register FIFO for region entries, generic over the payload type
`timescale 1ns/10ps

module addr_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_push,
	input  T     i_data,
	input  logic i_pop,
	output T     o_data,
	output logic o_full,
	output logic o_empty
);

	// ====================
	// Storage
	// ====================
	// Slot 0 is always the head
	T mem [DEPTH];
	// Occupancy, needs to reach DEPTH
	logic [$clog2(DEPTH+1)-1:0] cnt_r;
	// Slot that takes the new entry this cycle
	logic [$clog2(DEPTH+1)-1:0] wr_idx;

	assign o_full = (cnt_r == DEPTH);
	assign o_empty = (cnt_r == '0);
	assign o_data = mem[0];

	// A pop moves everything down one slot, so the free slot moves too
	assign wr_idx = i_pop ? cnt_r - 1'b1 : cnt_r;

	// ====================
	// Occupancy
	// ====================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			cnt_r <= '0;
		end else begin
			case ({i_push, i_pop})
				2'b10: cnt_r <= cnt_r + 1'b1;
				2'b01: cnt_r <= cnt_r - 1'b1;
				default: cnt_r <= cnt_r;
			endcase
		end
	end

	// ====================
	// Slot array
	// ====================
	always_ff @(posedge i_clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (i_push && (wr_idx == i)) begin
				// New entry lands in the first free slot
				mem[i] <= i_data;
			end else if (i_pop && (i < DEPTH - 1)) begin
				// Shift toward the head
				mem[i] <= mem[i+1];
			end
		end
	end

	// Owner gates pops on its own ready signal
	a_no_pop_empty: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		i_pop |-> !o_empty
	) else $error("addr_fifo popped while empty");

endmodule

// File: alloc_dispatch.sv
// Request and event router that looks up block sizes and fans out to banks
`timescale 1ns/10ps

module alloc_dispatch (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic                               i_alloc_rdy,
	input  logic [lbuf_pkg::BANK_BW-1:0]       i_alloc_bank,
	input  logic [lbuf_pkg::CFG_BW-1:0]        i_alloc_cfg,
	input  logic [lbuf_pkg::N_BANK-1:0]        i_bank_alloc_ack,
	input  logic                               i_free_dval,
	input  logic [lbuf_pkg::BANK_BW-1:0]       i_free_bank,
	input  logic [lbuf_pkg::CFG_BW-1:0]        i_free_cfg,
	input  logic                               i_re_dval,
	input  logic [lbuf_pkg::BANK_BW-1:0]       i_re_bank,
	input  logic                               i_blkdone_dval,
	input  logic [lbuf_pkg::BANK_BW-1:0]       i_blkdone_bank,
	output logic                               o_alloc_ack,
	output logic [lbuf_pkg::N_BANK-1:0]        o_bank_alloc_rdy,
	output logic [lbuf_pkg::LBW:0]             o_alloc_size,
	output logic [lbuf_pkg::N_BANK-1:0]        o_bank_free_dval,
	output logic [lbuf_pkg::LBW:0]             o_free_size,
	output logic [lbuf_pkg::N_BANK-1:0]        o_bank_re_dval,
	output logic [lbuf_pkg::N_BANK-1:0]        o_bank_blkdone_dval
);

	// One-hot event hits before the register stage
	logic [lbuf_pkg::N_BANK-1:0] free_hit;
	logic [lbuf_pkg::N_BANK-1:0] re_hit;
	logic [lbuf_pkg::N_BANK-1:0] blkdone_hit;

	// ====================
	// Request side
	// ====================
	// Size lookup is shared, only the ready goes to one bank
	assign o_alloc_size = lbuf_pkg::SIZE_TABLE[i_alloc_cfg];
	// Only the addressed bank can answer
	assign o_alloc_ack = |i_bank_alloc_ack;

	always_comb begin
		for (int b = 0; b < lbuf_pkg::N_BANK; b++) begin
			o_bank_alloc_rdy[b] = i_alloc_rdy && (i_alloc_bank == lbuf_pkg::BANK_BW'(b));
			free_hit[b] = i_free_dval && (i_free_bank == lbuf_pkg::BANK_BW'(b));
			re_hit[b] = i_re_dval && (i_re_bank == lbuf_pkg::BANK_BW'(b));
			blkdone_hit[b] = i_blkdone_dval && (i_blkdone_bank == lbuf_pkg::BANK_BW'(b));
		end
	end

	// ====================
	// Event register
	// ====================
	// Events reach the banks one clock after the strobe
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_bank_free_dval <= '0;
			o_bank_re_dval <= '0;
			o_bank_blkdone_dval <= '0;
		end else begin
			o_bank_free_dval <= free_hit;
			o_bank_re_dval <= re_hit;
			o_bank_blkdone_dval <= blkdone_hit;
		end
	end

	// Freed size travels alongside the registered strobe
	always_ff @(posedge i_clk) begin
		if (i_free_dval) begin
			o_free_size <= lbuf_pkg::SIZE_TABLE[i_free_cfg];
		end
	end

	a_ack_onehot: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		$onehot0(i_bank_alloc_ack)
	) else $error("alloc_dispatch saw more than one bank acknowledge");

	a_ack_has_rdy: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(i_bank_alloc_ack & ~o_bank_alloc_rdy) == '0
	) else $error("alloc_dispatch saw a bank acknowledge without ready");

endmodule

// File: bank_allocator.sv
// Single scratchpad bank with capacity, cursor, written-word count and region queue
`timescale 1ns/10ps

module bank_allocator (
	input  logic                       i_clk,
	input  logic                       i_rst,
	// Allocation request, ready/acknowledge
	input  logic                       i_alloc_rdy,
	input  logic [lbuf_pkg::LBW:0]     i_alloc_size,
	output logic                       o_alloc_ack,
	// Registered events from the dispatcher
	input  logic                       i_free_dval,
	input  logic [lbuf_pkg::LBW:0]     i_free_size,
	input  logic                       i_re_dval,
	input  logic                       i_blkdone_dval,
	// Released region, ready/acknowledge
	output logic                       o_linear_rdy,
	input  logic                       i_linear_ack,
	output logic [lbuf_pkg::LBW-1:0]   o_linear_addr,
	output logic [lbuf_pkg::LBW:0]     o_linear_size
);

	// ====================
	// State
	// ====================
	// Free words left in the bank
	logic [lbuf_pkg::LBW:0]   capacity_r;
	logic [lbuf_pkg::LBW:0]   capacity_w;
	// Next write address that wraps with the bank
	logic [lbuf_pkg::LBW-1:0] cur_r;
	logic [lbuf_pkg::LBW-1:0] cur_w;
	// Words written but not yet released
	logic [lbuf_pkg::LBW:0]   valid_r;
	logic [lbuf_pkg::LBW:0]   valid_w;

	// Queue of granted regions
	lbuf_pkg::lin_entry_t push_entry;
	lbuf_pkg::lin_entry_t head_entry;
	logic fifo_full;
	logic fifo_empty;
	logic fifo_pop;

	logic has_space;

	// ====================
	// Region queue
	// ====================
	assign push_entry.addr = cur_r;
	assign push_entry.size = i_alloc_size;

	addr_fifo #(
		.T(lbuf_pkg::lin_entry_t),
		.DEPTH(lbuf_pkg::FIFO_DEPTH)
	) u_region_fifo (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_push(o_alloc_ack),
		.i_data(push_entry),
		.i_pop(fifo_pop),
		.o_data(head_entry),
		.o_full(fifo_full),
		.o_empty(fifo_empty)
	);

	// ====================
	// Handshakes
	// ====================
	// Grant needs both room in the bank and a slot in the queue
	assign has_space = (capacity_r >= i_alloc_size);
	assign o_alloc_ack = i_alloc_rdy && has_space && !fifo_full;

	// Head leaves only once its words are all written
	assign o_linear_rdy = !fifo_empty && (valid_r >= head_entry.size);
	assign o_linear_addr = head_entry.addr;
	assign o_linear_size = head_entry.size;
	assign fifo_pop = o_linear_rdy && i_linear_ack;

	// ====================
	// Next state
	// ====================
	always_comb begin
		case ({o_alloc_ack, i_free_dval})
			2'b01: capacity_w = capacity_r + i_free_size;
			2'b10: capacity_w = capacity_r - i_alloc_size;
			2'b11: capacity_w = capacity_r - i_alloc_size + i_free_size;
			default: capacity_w = capacity_r;
		endcase
	end

	always_comb begin
		// Release and a write event may land together
		case ({fifo_pop, i_re_dval})
			2'b01: valid_w = valid_r + lbuf_pkg::VSIZE;
			2'b10: valid_w = valid_r - head_entry.size;
			2'b11: valid_w = valid_r - head_entry.size + lbuf_pkg::VSIZE;
			default: valid_w = valid_r;
		endcase
	end

	always_comb begin
		// Block done wins and a grant in the same cycle still used the old cursor
		if (i_blkdone_dval) begin
			cur_w = '0;
		end else if (o_alloc_ack) begin
			// Carry is dropped because the bank is circular
			cur_w = cur_r + i_alloc_size[lbuf_pkg::LBW-1:0];
		end else begin
			cur_w = cur_r;
		end
	end

	// ====================
	// Registers
	// ====================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			capacity_r <= lbuf_pkg::CAPACITY;
			cur_r <= '0;
			valid_r <= '0;
		end else begin
			capacity_r <= capacity_w;
			cur_r <= cur_w;
			valid_r <= valid_w;
		end
	end

	// Frees must match earlier grants
	a_cap_bound: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		capacity_r <= lbuf_pkg::CAPACITY
	) else $error("bank_allocator capacity above bank size");

endmodule

// File: lbuf_pkg.sv
// Local-buffer allocator constants, size table and region entry types
package lbuf_pkg;

	// ====================
	// Configurations
	// ====================
	// Block configurations known to the allocator
	localparam int N_CFG = 4;
	localparam int CFG_BW = 2;

	// ====================
	// Bank geometry
	// ====================
	// Bank address width, one bank is 2**LBW words
	localparam int LBW = 6;
	// Capacity needs one extra bit to hold a completely free bank
	localparam logic [LBW:0] CAPACITY = 1 << LBW;
	// Words written per write event
	localparam logic [LBW:0] VSIZE = 4;

	// Block size per configuration in words
	// Entry 0 is the lowest slice, each entry a multiple of VSIZE
	localparam logic [N_CFG-1:0][LBW:0] SIZE_TABLE = {7'd16, 7'd12, 7'd8, 7'd4};

	// ====================
	// Banks and queues
	// ====================
	localparam int N_BANK = 2;
	localparam int BANK_BW = 1;
	// Pending regions held per bank
	localparam int FIFO_DEPTH = 4;

	// Region granted inside one bank
	typedef struct packed {
		logic [LBW-1:0] addr;
		logic [LBW:0]   size;
	} lin_entry_t;

	// Released region tagged with the bank it came from
	typedef struct packed {
		logic [BANK_BW-1:0] bank;
		logic [LBW-1:0]     addr;
		logic [LBW:0]       size;
	} out_entry_t;

endpackage

// File: lbuf_subsys.sv
// Local-buffer allocator top with dispatcher, bank array and release collector
`timescale 1ns/10ps

module lbuf_subsys (
	input  logic                         i_clk,
	input  logic                         i_rst,
	input  logic                         i_alloc_rdy,
	output logic                         o_alloc_ack,
	input  logic [lbuf_pkg::BANK_BW-1:0] i_alloc_bank,
	input  logic [lbuf_pkg::CFG_BW-1:0]  i_alloc_cfg,
	input  logic                         i_free_dval,
	input  logic [lbuf_pkg::BANK_BW-1:0] i_free_bank,
	input  logic [lbuf_pkg::CFG_BW-1:0]  i_free_cfg,
	input  logic                         i_re_dval,
	input  logic [lbuf_pkg::BANK_BW-1:0] i_re_bank,
	input  logic                         i_blkdone_dval,
	input  logic [lbuf_pkg::BANK_BW-1:0] i_blkdone_bank,
	output logic                         o_linear_rdy,
	input  logic                         i_linear_ack,
	output logic [lbuf_pkg::BANK_BW-1:0] o_linear_bank,
	output logic [lbuf_pkg::LBW-1:0]     o_linear_addr,
	output logic [lbuf_pkg::LBW:0]       o_linear_size
);

	// ====================
	// Request side wires
	// ====================
	logic [lbuf_pkg::N_BANK-1:0] bank_alloc_rdy;
	logic [lbuf_pkg::N_BANK-1:0] bank_alloc_ack;
	logic [lbuf_pkg::LBW:0]      alloc_size;
	logic [lbuf_pkg::N_BANK-1:0] bank_free_dval;
	logic [lbuf_pkg::LBW:0]      free_size;
	logic [lbuf_pkg::N_BANK-1:0] bank_re_dval;
	logic [lbuf_pkg::N_BANK-1:0] bank_blkdone_dval;

	// Release side wires
	logic [lbuf_pkg::N_BANK-1:0] bank_linear_rdy;
	logic [lbuf_pkg::N_BANK-1:0] bank_linear_ack;
	logic [lbuf_pkg::LBW-1:0]    bank_linear_addr [lbuf_pkg::N_BANK];
	logic [lbuf_pkg::LBW:0]      bank_linear_size [lbuf_pkg::N_BANK];

	alloc_dispatch u_dispatch (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_alloc_rdy(i_alloc_rdy),
		.i_alloc_bank(i_alloc_bank),
		.i_alloc_cfg(i_alloc_cfg),
		.i_bank_alloc_ack(bank_alloc_ack),
		.i_free_dval(i_free_dval),
		.i_free_bank(i_free_bank),
		.i_free_cfg(i_free_cfg),
		.i_re_dval(i_re_dval),
		.i_re_bank(i_re_bank),
		.i_blkdone_dval(i_blkdone_dval),
		.i_blkdone_bank(i_blkdone_bank),
		.o_alloc_ack(o_alloc_ack),
		.o_bank_alloc_rdy(bank_alloc_rdy),
		.o_alloc_size(alloc_size),
		.o_bank_free_dval(bank_free_dval),
		.o_free_size(free_size),
		.o_bank_re_dval(bank_re_dval),
		.o_bank_blkdone_dval(bank_blkdone_dval)
	);

	// ====================
	// Bank array
	// ====================
	for (genvar gb = 0; gb < lbuf_pkg::N_BANK; gb++) begin : g_bank
		bank_allocator u_bank (
			.i_clk(i_clk),
			.i_rst(i_rst),
			.i_alloc_rdy(bank_alloc_rdy[gb]),
			.i_alloc_size(alloc_size),
			.o_alloc_ack(bank_alloc_ack[gb]),
			.i_free_dval(bank_free_dval[gb]),
			.i_free_size(free_size),
			.i_re_dval(bank_re_dval[gb]),
			.i_blkdone_dval(bank_blkdone_dval[gb]),
			.o_linear_rdy(bank_linear_rdy[gb]),
			.i_linear_ack(bank_linear_ack[gb]),
			.o_linear_addr(bank_linear_addr[gb]),
			.o_linear_size(bank_linear_size[gb])
		);
	end

	addr_collector u_collector (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_bank_rdy(bank_linear_rdy),
		.i_bank_addr(bank_linear_addr),
		.i_bank_size(bank_linear_size),
		.o_bank_ack(bank_linear_ack),
		.o_linear_rdy(o_linear_rdy),
		.i_linear_ack(i_linear_ack),
		.o_linear_bank(o_linear_bank),
		.o_linear_addr(o_linear_addr),
		.o_linear_size(o_linear_size)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_lbuf_subsys -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation did not pass"; exit 1; }

// File: src.f
lbuf_pkg.sv
addr_fifo.sv
alloc_dispatch.sv
bank_allocator.sv
addr_collector.sv
lbuf_subsys.sv
tb_lbuf_subsys.sv

// File: tb_lbuf_subsys.sv
// Random-stimulus testbench for the local-buffer allocator with a cycle model of banks and collector
`timescale 1ns/10ps

module tb_lbuf_subsys;

	localparam int STIM_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 1000;
	localparam int TIMEOUT = STIM_CYCLES + DRAIN_CYCLES;
	localparam int BANK_WORDS = 64;
	localparam int NB = lbuf_pkg::N_BANK;

	logic                         i_clk = 1'b0;
	logic                         i_rst;
	logic                         i_alloc_rdy;
	logic                         o_alloc_ack;
	logic [lbuf_pkg::BANK_BW-1:0] i_alloc_bank;
	logic [lbuf_pkg::CFG_BW-1:0]  i_alloc_cfg;
	logic                         i_free_dval;
	logic [lbuf_pkg::BANK_BW-1:0] i_free_bank;
	logic [lbuf_pkg::CFG_BW-1:0]  i_free_cfg;
	logic                         i_re_dval;
	logic [lbuf_pkg::BANK_BW-1:0] i_re_bank;
	logic                         i_blkdone_dval;
	logic [lbuf_pkg::BANK_BW-1:0] i_blkdone_bank;
	logic                         o_linear_rdy;
	logic                         i_linear_ack;
	logic [lbuf_pkg::BANK_BW-1:0] o_linear_bank;
	logic [lbuf_pkg::LBW-1:0]     o_linear_addr;
	logic [lbuf_pkg::LBW:0]       o_linear_size;

	// ====================
	// Model state
	// ====================
	// Block sizes 4, 8, 12 and 16 words
	int size_of [lbuf_pkg::N_CFG] = '{4, 8, 12, 16};
	int cap [NB];
	int cur [NB];
	int valid [NB];
	// Granted regions still inside each bank
	lbuf_pkg::lin_entry_t bq [NB][$];
	// Collector output buffer
	lbuf_pkg::out_entry_t cq [$];
	int rr;
	// Configs granted and not yet freed
	logic [lbuf_pkg::CFG_BW-1:0] owned [NB][$];
	int issued_wr [NB];
	int alloc_cum [NB];
	int wr_cum [NB];
	int rel_cum [NB];
	// Strobes seen last cycle that the banks act on one clock later
	bit free_pend [NB];
	bit re_pend [NB];
	bit blk_pend [NB];
	int free_sz;

	logic [31:0] rng_state = 32'd23;
	int cycle;
	int low_left;
	int alloc_cnt;
	int out_cnt;
	int ack_errs;
	int entry_errs;
	int other_errs;
	bit acked;
	bit drained;

	always #20 i_clk = ~i_clk;

	lbuf_subsys i_lbuf_subsys (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] draw();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic check_ack(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			ack_errs++;
			$display("FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
		end
	endtask

	task automatic check_entry(input lbuf_pkg::out_entry_t got, input lbuf_pkg::out_entry_t exp,
		input string name);
		if (got !== exp) begin
			entry_errs++;
			$display("FAILED t=%0t %s got=%0h/%0h/%0h exp=%0h/%0h/%0h", $time, name,
				got.bank, got.addr, got.size, exp.bank, exp.addr, exp.size);
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	task automatic drive_inputs(input bit stim_on);
		logic [31:0] r;
		int fb;
		int rb;
		r = draw();
		// Request stays up with the same data until granted
		if (!i_alloc_rdy || acked) begin
			i_alloc_rdy = stim_on && (r[2:0] != 3'd0);
			i_alloc_bank = lbuf_pkg::BANK_BW'(int'(r[7:3]) % NB);
			i_alloc_cfg = r[9:8];
		end
		// Free only what was granted and oldest first
		fb = int'(r[12:10]) % NB;
		i_free_dval = 1'b0;
		if (owned[fb].size() != 0 && r[15:13] < 3'd2) begin
			i_free_dval = 1'b1;
			i_free_bank = lbuf_pkg::BANK_BW'(fb);
			i_free_cfg = owned[fb].pop_front();
		end
		// Writes never run ahead of granted words
		rb = int'(r[18:16]) % NB;
		if (issued_wr[rb] + 4 > alloc_cum[rb])
			rb = (rb + 1) % NB;
		i_re_dval = (issued_wr[rb] + 4 <= alloc_cum[rb]) && (!stim_on || r[20:19] != 2'd0);
		i_re_bank = lbuf_pkg::BANK_BW'(rb);
		if (i_re_dval)
			issued_wr[rb] += 4;
		i_blkdone_dval = stim_on && (r[25:21] == 5'd0);
		i_blkdone_bank = lbuf_pkg::BANK_BW'(int'(r[26]) % NB);
		// Back-pressure in bursts of 1 to 7 cycles
		if (low_left != 0)
			low_left--;
		else if (stim_on && r[29:27] == 3'd0)
			low_left = 1 + int'(r[31:30]) * 2;
		i_linear_ack = (low_left == 0);
	endtask

	// ====================
	// Cycle model and checks
	// ====================
	task automatic step_model();
		int ab;
		int asz;
		int b;
		int sel;
		int ob;
		bit found;
		bit grant;
		bit exp_ack;
		lbuf_pkg::out_entry_t got;
		lbuf_pkg::out_entry_t e;
		lbuf_pkg::lin_entry_t le;
		ab = int'(i_alloc_bank);
		asz = size_of[i_alloc_cfg];
		exp_ack = i_alloc_rdy && cap[ab] >= asz && bq[ab].size() < lbuf_pkg::FIFO_DEPTH;
		check_ack(o_alloc_ack, exp_ack, "o_alloc_ack");
		// Offered entry is compared every cycle while the model head moves only on acknowledge
		check_ack(o_linear_rdy, cq.size() != 0, "o_linear_rdy");
		if (cq.size() != 0) begin
			got.bank = o_linear_bank;
			got.addr = o_linear_addr;
			got.size = o_linear_size;
			check_entry(got, cq[0], "o_linear");
		end
		// Words released by the DUT may never exceed words written to that bank
		if (o_linear_rdy === 1'b1 && i_linear_ack) begin
			ob = int'(o_linear_bank);
			rel_cum[ob] += int'(o_linear_size);
			if (rel_cum[ob] > wr_cum[ob]) begin
				other_errs++;
				$display("Region left bank %0d before its words were written", ob);
			end
		end
		// Round-robin over banks whose head region is fully written
		found = 1'b0;
		sel = rr;
		for (int k = 0; k < NB; k++) begin
			b = (rr + k) % NB;
			if (!found && bq[b].size() != 0 && valid[b] >= int'(bq[b][0].size)) begin
				found = 1'b1;
				sel = b;
			end
		end
		grant = found && cq.size() < lbuf_pkg::FIFO_DEPTH;
		if (cq.size() != 0 && i_linear_ack) begin
			e = cq.pop_front();
			out_cnt++;
		end
		if (grant) begin
			le = bq[sel].pop_front();
			e.bank = lbuf_pkg::BANK_BW'(sel);
			e.addr = le.addr;
			e.size = le.size;
			cq.push_back(e);
			valid[sel] -= int'(le.size);
			rr = (sel + 1) % NB;
		end
		for (int k = 0; k < NB; k++) begin
			if (re_pend[k]) begin
				valid[k] += 4;
				wr_cum[k] += 4;
			end
			if (free_pend[k])
				cap[k] += free_sz;
		end
		if (exp_ack) begin
			le.addr = lbuf_pkg::LBW'(cur[ab]);
			le.size = asz[lbuf_pkg::LBW:0];
			bq[ab].push_back(le);
			cap[ab] -= asz;
			cur[ab] = (cur[ab] + asz) % BANK_WORDS;
			alloc_cum[ab] += asz;
			owned[ab].push_back(i_alloc_cfg);
			alloc_cnt++;
		end
		// Block done wins over the cursor step
		for (int k = 0; k < NB; k++) begin
			if (blk_pend[k])
				cur[k] = 0;
			free_pend[k] = i_free_dval && int'(i_free_bank) == k;
			re_pend[k] = i_re_dval && int'(i_re_bank) == k;
			blk_pend[k] = i_blkdone_dval && int'(i_blkdone_bank) == k;
		end
		if (i_free_dval)
			free_sz = size_of[i_free_cfg];
		acked = exp_ack;
	endtask

	initial begin
		i_rst = 1'b0;
		i_alloc_rdy = 1'b0;
		i_alloc_bank = '0;
		i_alloc_cfg = '0;
		i_free_dval = 1'b0;
		i_free_bank = '0;
		i_free_cfg = '0;
		i_re_dval = 1'b0;
		i_re_bank = '0;
		i_blkdone_dval = 1'b0;
		i_blkdone_bank = '0;
		i_linear_ack = 1'b0;
		for (int k = 0; k < NB; k++) begin
			cap[k] = BANK_WORDS;
		end
		repeat (2) @(negedge i_clk);
		i_rst = 1'b1;
		while (cycle < TIMEOUT && !drained) begin
			@(negedge i_clk);
			drive_inputs(cycle < STIM_CYCLES);
			// Let the combinational handshakes settle
			#1;
			step_model();
			cycle++;
			drained = cycle >= STIM_CYCLES && !i_alloc_rdy && out_cnt == alloc_cnt;
		end
		if (!drained) begin
			other_errs++;
			$display("Timeout after %0d cycles with %0d regions still inside", cycle,
				alloc_cnt - out_cnt);
		end
		$display("Regions %0d granted %0d released, errors ack=%0d entry=%0d other=%0d",
			alloc_cnt, out_cnt, ack_errs, entry_errs, other_errs);
		if (ack_errs + entry_errs + other_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
